//--- access_decode.sv
/*
 * Access decode
 * splits an LSU access into translation mode and lookup tag, and turns
 * the raw refill port into a TLB update record
 */
`default_nettype none

module access_decode (
  input  wire logic                     lsu_req_i,
  input  wire logic [mmu_pkg::VLEN-1:0] lsu_vaddr_i,
  input  wire logic                     lsu_is_store_i,
  input  wire logic                     misaligned_i,
  input  wire logic [1:0]               priv_i,
  input  wire logic                     en_translation_i,
  input  wire logic                     sum_i,
  input  wire logic                     mxr_i,
  input  wire logic                     upd_valid_i,
  input  wire logic [mmu_pkg::VPNW-1:0] upd_vpn_i,
  input  wire logic                     upd_mega_i,
  input  wire logic [31:0]              upd_pte_i,
  dtlb_if.requester                     lu,
  output mmu_pkg::tlb_update_t          update_o,
  output logic                          req_o,
  output logic                          xlate_on_o,
  output logic                          is_store_o,
  output logic                          mis_o,
  output logic [1:0]                    priv_o,
  output logic                          sum_o,
  output logic                          mxr_o,
  output mmu_pkg::vaddr_u               vaddr_o
);

  mmu_pkg::vaddr_u va;
  mmu_pkg::pte_t   upd_pte;

  // ----------------------------------------------------------------------
  // access side
  // ----------------------------------------------------------------------
  assign va = lsu_vaddr_i;

  // tag is always the full 4 KiB vpn, megapage entries ignore vpn0
  assign lu.vpn = {va.page.vpn1, va.page.vpn0};

  // machine mode never translates
  assign xlate_on_o = en_translation_i && (priv_i != mmu_pkg::PRIV_M);

  // a stale misaligned flag without a request must not raise anything
  assign mis_o = misaligned_i & lsu_req_i;

  assign req_o      = lsu_req_i;
  assign is_store_o = lsu_is_store_i;
  assign priv_o     = priv_i;
  assign sum_o      = sum_i;
  assign mxr_o      = mxr_i;
  assign vaddr_o    = va;

  // ----------------------------------------------------------------------
  // refill side
  // ----------------------------------------------------------------------
  assign upd_pte = mmu_pkg::pte_t'(upd_pte_i);

  always_comb begin
    update_o.valid   = upd_valid_i & upd_pte.v;
    update_o.vpn     = upd_vpn_i;
    update_o.mega    = upd_mega_i;
    update_o.content = upd_pte;
  end

endmodule

`default_nettype wire

//--- dtlb_array.sv
/*
 * Data TLB storage
 * fully associative, parallel tag compare, refill into the first free
 * entry or a round-robin victim, flush of all entries
 */
`default_nettype none

module dtlb_array (
  input  wire logic                 clk_i,
  input  wire logic                 rst_ni,
  input  wire logic                 flush_i,
  input  wire mmu_pkg::tlb_update_t update_i,
  dtlb_if.responder                 lu
);

  localparam int unsigned N = mmu_pkg::DTLB_ENTRIES;

  logic [N-1:0]                    valid_q;
  logic [mmu_pkg::VPNW-1:0]        tag_vpn_q  [N];
  logic                            tag_mega_q [N];
  mmu_pkg::pte_t                   pte_q      [N];

  logic [N-1:0]                    match;
  logic                            free_found;
  logic [mmu_pkg::DTLB_IDXW-1:0]   free_idx;
  logic [mmu_pkg::DTLB_IDXW-1:0]   victim_q;
  logic [mmu_pkg::DTLB_IDXW-1:0]   victim_nxt;
  logic [mmu_pkg::DTLB_IDXW-1:0]   wr_idx;

  // ----------------------------------------------------------------------
  // lookup
  // ----------------------------------------------------------------------
  always_comb begin
    for (int unsigned i = 0; i < N; i++) begin
      match[i] = valid_q[i]
              && (tag_vpn_q[i][mmu_pkg::VPNW-1:10] == lu.vpn[mmu_pkg::VPNW-1:10])
              && (tag_mega_q[i] || (tag_vpn_q[i][9:0] == lu.vpn[9:0]));
    end
  end

  // lowest matching entry wins if a page was refilled twice
  always_comb begin
    logic found;
    found   = 1'b0;
    lu.pte  = '0;
    lu.mega = 1'b0;
    for (int unsigned i = 0; i < N; i++) begin
      if (match[i] && !found) begin
        found   = 1'b1;
        lu.pte  = pte_q[i];
        lu.mega = tag_mega_q[i];
      end
    end
    lu.hit = found;
  end

  // ----------------------------------------------------------------------
  // replacement
  // ----------------------------------------------------------------------
  always_comb begin
    free_found = 1'b0;
    free_idx   = '0;
    for (int unsigned i = 0; i < N; i++) begin
      if (!valid_q[i] && !free_found) begin
        free_found = 1'b1;
        free_idx   = mmu_pkg::DTLB_IDXW'(i);
      end
    end
  end

  assign victim_nxt = (victim_q == mmu_pkg::DTLB_IDXW'(N - 1)) ? '0 : victim_q + 1'b1;
  assign wr_idx     = free_found ? free_idx : victim_q;

  // flush beats a refill in the same cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q  <= '0;
      victim_q <= '0;
    end else if (flush_i) begin
      valid_q  <= '0;
      victim_q <= '0;
    end else if (update_i.valid) begin
      valid_q[wr_idx] <= 1'b1;
      // pointer only moves when it actually picked the slot
      if (!free_found) begin
        victim_q <= victim_nxt;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (update_i.valid && !flush_i) begin
      tag_vpn_q[wr_idx]  <= update_i.vpn;
      tag_mega_q[wr_idx] <= update_i.mega;
      pte_q[wr_idx]      <= update_i.content;
    end
  end

endmodule

`default_nettype wire

//--- dtlb_if.sv
/*
 * DTLB lookup channel
 * tag from the decode stage, hit and entry back for the result stage
 */
`default_nettype none

interface dtlb_if;

  logic [mmu_pkg::VPNW-1:0] vpn;
  logic                     hit;
  mmu_pkg::pte_t            pte;
  logic                     mega;

  modport requester (
    output vpn
  );

  modport responder (
    input  vpn,
    output hit,
    output pte,
    output mega
  );

  // result stage only samples the answer
  modport monitor (
    input hit,
    input pte,
    input mega
  );

endinterface

`default_nettype wire

//--- mmu_pkg.sv
/*
 * Sv32 data MMU shared definitions
 * widths, exception causes, page table entry, TLB refill record and the
 * virtual address union used by the decode and result stages
 */
`default_nettype none

package mmu_pkg;

  // ----------------------------------------------------------------------
  // widths and sizes
  // ----------------------------------------------------------------------
  localparam int unsigned VLEN         = 32;
  localparam int unsigned PLEN         = 34;
  localparam int unsigned PPNW         = 22;
  localparam int unsigned VPNW         = 20;
  localparam int unsigned OFFW         = 12;
  localparam int unsigned DTLB_ENTRIES = 8;
  localparam int unsigned DTLB_IDXW    = $clog2(DTLB_ENTRIES);

  // exception causes as reported in mcause/scause
  localparam logic [3:0] CAUSE_LD_MISALIGNED = 4'd4;
  localparam logic [3:0] CAUSE_ST_MISALIGNED = 4'd6;
  localparam logic [3:0] CAUSE_LD_PAGE_FAULT = 4'd13;
  localparam logic [3:0] CAUSE_ST_PAGE_FAULT = 4'd15;

  // privilege levels
  localparam logic [1:0] PRIV_U = 2'b00;
  localparam logic [1:0] PRIV_S = 2'b01;
  localparam logic [1:0] PRIV_M = 2'b11;

  // ----------------------------------------------------------------------
  // types
  // ----------------------------------------------------------------------
  typedef struct packed {
    logic [11:0] ppn1;
    logic [9:0]  ppn0;
    logic [1:0]  rsw;
    logic        d;
    logic        a;
    logic        g;
    logic        u;
    logic        x;
    logic        w;
    logic        r;
    logic        v;
  } pte_t;

  typedef struct packed {
    logic [9:0]      vpn1;
    logic [9:0]      vpn0;
    logic [OFFW-1:0] offset;
  } vaddr_page_t;

  // a megapage maps the whole lower 22 bits straight through
  typedef struct packed {
    logic [9:0]  vpn1;
    logic [21:0] offset;
  } vaddr_mega_t;

  typedef union packed {
    vaddr_page_t page;
    vaddr_mega_t mega;
  } vaddr_u;

  typedef struct packed {
    logic            valid;
    logic [VPNW-1:0] vpn;
    logic            mega;
    pte_t            content;
  } tlb_update_t;

  typedef struct packed {
    logic            valid;
    logic [3:0]      cause;
    logic [VLEN-1:0] tval;
  } exc_t;

endpackage

`default_nettype wire

//--- mmu_trace.txt
# refill <vpn> <mega> <pte> | flush | access <vaddr> <store> <mis> <priv> <en> <sum> <mxr>
# access expects <hit> <valid> <paddr> <exc_valid> <cause>, all fields hex
access 80001234 0 0 1 0 0 0 1 1 080001234 0 0
access fffff008 1 0 3 1 0 0 1 1 0fffff008 0 0
access 40000010 0 0 1 1 0 0 0 0 000000000 0 0
refill 40000 0 048d14cf
access 40000010 0 0 1 1 0 0 1 1 012345010 0 0
access 40000abc 1 0 1 1 0 0 1 1 012345abc 0 0
refill 80400 1 3ab000cf
access 80678abc 0 0 1 1 0 0 1 1 0eae78abc 0 0
refill 10001 0 002af043
access 10001004 1 0 1 1 0 0 1 1 000000000 1 f
access 10001004 0 0 1 1 0 0 1 1 000abc004 0 0
refill 10002 0 002af447
access 10002008 1 0 1 1 0 0 1 1 000000000 1 f
refill 10003 0 002af849
access 10003000 0 0 1 1 0 0 1 1 000000000 1 d
access 10003000 0 0 1 1 0 1 1 1 000abe000 0 0
refill 20000 0 004000df
access 20000040 0 0 1 1 0 0 1 1 000000000 1 d
access 20000040 1 0 1 1 1 0 1 1 001000040 0 0
access 20000040 0 0 0 1 0 0 1 1 001000040 0 0
access 40000010 0 0 0 1 0 0 1 1 000000000 1 d
access 40000011 1 1 1 1 0 0 1 1 000000000 1 6
access 80400003 0 1 1 1 0 0 1 1 000000000 1 4
refill 30000 0 014000cf
refill 30001 0 014004cf
refill 30002 0 014008cf
access 40000010 0 0 1 1 0 0 0 0 000000000 0 0
access 30002000 0 0 1 1 0 0 1 1 005002000 0 0
access 80400100 0 0 1 1 0 0 1 1 0eac00100 0 0
refill 30003 0 01400ccf
access 80400100 0 0 1 1 0 0 0 0 000000000 0 0
access 10001004 0 0 1 1 0 0 1 1 000abc004 0 0
flush
access 30002000 0 0 1 1 0 0 0 0 000000000 0 0
refill 30002 0 014008cf
access 30002000 0 0 1 1 0 0 1 1 005002000 0 0
access 10001004 0 0 0 0 0 0 1 1 010001004 0 0
refill 50000 0 01800087
access 50000000 0 0 1 1 0 0 1 1 000000000 1 d

//--- project.f
mmu_pkg.sv
dtlb_if.sv
access_decode.sv
dtlb_array.sv
xlate_result.sv
sv32_mmu.sv
tb_sv32_mmu.sv

//--- run_sim.sh
#!/bin/sh
# build and run the Sv32 data MMU testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
  -f project.f --top-module tb_sv32_mmu -o tb_sv32_mmu

./obj_dir/tb_sv32_mmu > sim.log 2>&1
cat sim.log

if grep -q "Test failed" sim.log; then
  echo "simulation reported a failure, see sim.log"
  exit 1
fi
echo "simulation finished without failure"

//--- sv32_mmu.sv
/*
 * Sv32 data MMU top level
 * decode, DTLB lookup and registered result for LSU accesses
 */
`default_nettype none

module sv32_mmu (
  input  wire logic                     clk_i,
  input  wire logic                     rst_ni,
  input  wire logic                     flush_i,
  // LSU access
  input  wire logic                     lsu_req_i,
  input  wire logic [mmu_pkg::VLEN-1:0] lsu_vaddr_i,
  input  wire logic                     lsu_is_store_i,
  input  wire logic                     misaligned_i,
  input  wire logic [1:0]               priv_i,
  input  wire logic                     en_translation_i,
  input  wire logic                     sum_i,
  input  wire logic                     mxr_i,
  // TLB refill
  input  wire logic                     upd_valid_i,
  input  wire logic [mmu_pkg::VPNW-1:0] upd_vpn_i,
  input  wire logic                     upd_mega_i,
  input  wire logic [31:0]              upd_pte_i,
  // cycle 0
  output logic                          lsu_dtlb_hit_o,
  // cycle 1
  output logic                          lsu_valid_o,
  output logic [mmu_pkg::PLEN-1:0]      lsu_paddr_o,
  output mmu_pkg::exc_t                 lsu_exception_o
);

  dtlb_if lu ();

  mmu_pkg::tlb_update_t update;
  logic                 req;
  logic                 xlate_on;
  logic                 is_store;
  logic                 mis;
  logic [1:0]           priv;
  logic                 sum;
  logic                 mxr;
  mmu_pkg::vaddr_u      vaddr;

  // ----------------------------------------------------------------------
  // decode
  // ----------------------------------------------------------------------
  access_decode u_decode (
    .lsu_req_i        (lsu_req_i),
    .lsu_vaddr_i      (lsu_vaddr_i),
    .lsu_is_store_i   (lsu_is_store_i),
    .misaligned_i     (misaligned_i),
    .priv_i           (priv_i),
    .en_translation_i (en_translation_i),
    .sum_i            (sum_i),
    .mxr_i            (mxr_i),
    .upd_valid_i      (upd_valid_i),
    .upd_vpn_i        (upd_vpn_i),
    .upd_mega_i       (upd_mega_i),
    .upd_pte_i        (upd_pte_i),
    .lu               (lu.requester),
    .update_o         (update),
    .req_o            (req),
    .xlate_on_o       (xlate_on),
    .is_store_o       (is_store),
    .mis_o            (mis),
    .priv_o           (priv),
    .sum_o            (sum),
    .mxr_o            (mxr),
    .vaddr_o          (vaddr)
  );

  // ----------------------------------------------------------------------
  // lookup and result
  // ----------------------------------------------------------------------
  dtlb_array u_dtlb (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .flush_i  (flush_i),
    .update_i (update),
    .lu       (lu.responder)
  );

  xlate_result u_result (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .req_i           (req),
    .xlate_on_i      (xlate_on),
    .is_store_i      (is_store),
    .mis_i           (mis),
    .priv_i          (priv),
    .sum_i           (sum),
    .mxr_i           (mxr),
    .vaddr_i         (vaddr),
    .lu              (lu.monitor),
    .lsu_dtlb_hit_o  (lsu_dtlb_hit_o),
    .lsu_valid_o     (lsu_valid_o),
    .lsu_paddr_o     (lsu_paddr_o),
    .lsu_exception_o (lsu_exception_o)
  );

endmodule

`default_nettype wire

//--- tb_sv32_mmu.sv
/*
 * Testbench for the Sv32 data MMU
 * plays refills, flushes and accesses from a trace file and checks the
 * cycle 0 hit and the cycle 1 result of every access
 */
`default_nettype none

module tb_sv32_mmu;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned MAX_RECORDS = 1000;

  logic                     clk;
  logic                     rst_n;
  logic                     flush;
  logic                     lsu_req;
  logic [mmu_pkg::VLEN-1:0] lsu_vaddr;
  logic                     lsu_is_store;
  logic                     misaligned;
  logic [1:0]               priv;
  logic                     en_translation;
  logic                     sum;
  logic                     mxr;
  logic                     upd_valid;
  logic [mmu_pkg::VPNW-1:0] upd_vpn;
  logic                     upd_mega;
  logic [31:0]              upd_pte;
  logic                     lsu_dtlb_hit;
  logic                     lsu_valid;
  logic [mmu_pkg::PLEN-1:0] lsu_paddr;
  mmu_pkg::exc_t            lsu_exception;

  // fields of the current trace record
  logic [31:0]              t_vaddr;
  logic                     t_store;
  logic                     t_mis;
  logic [1:0]               t_priv;
  logic                     t_en;
  logic                     t_sum;
  logic                     t_mxr;
  logic                     t_hit;
  logic                     t_valid;
  logic [mmu_pkg::PLEN-1:0] t_paddr;
  logic                     t_exc;
  logic [3:0]               t_cause;

  int unsigned test_cnt;
  int unsigned check_cnt;
  int unsigned error_cnt;

  sv32_mmu UUT (
    .clk_i            (clk),
    .rst_ni           (rst_n),
    .flush_i          (flush),
    .lsu_req_i        (lsu_req),
    .lsu_vaddr_i      (lsu_vaddr),
    .lsu_is_store_i   (lsu_is_store),
    .misaligned_i     (misaligned),
    .priv_i           (priv),
    .en_translation_i (en_translation),
    .sum_i            (sum),
    .mxr_i            (mxr),
    .upd_valid_i      (upd_valid),
    .upd_vpn_i        (upd_vpn),
    .upd_mega_i       (upd_mega),
    .upd_pte_i        (upd_pte),
    .lsu_dtlb_hit_o   (lsu_dtlb_hit),
    .lsu_valid_o      (lsu_valid),
    .lsu_paddr_o      (lsu_paddr),
    .lsu_exception_o  (lsu_exception)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // ----------------------------------------------------------------------
  // checking and stimulus
  // ----------------------------------------------------------------------
  task automatic check_value(input string what, input logic [63:0] got,
                             input logic [63:0] exp);
    check_cnt++;
    if (got !== exp) begin
      error_cnt++;
      $display("FAILED at time %0t: test %0d %s is %0h, expected %0h",
               $time, test_cnt + 1, what, got, exp);
    end
  endtask

  task automatic refill_tlb(input logic [19:0] vpn, input logic mega, input logic [31:0] pte);
    @(posedge clk);
    upd_valid <= 1'b1;
    upd_vpn   <= vpn;
    upd_mega  <= mega;
    upd_pte   <= pte;
    @(posedge clk);
    upd_valid <= 1'b0;
  endtask

  task automatic flush_tlb();
    @(posedge clk);
    flush <= 1'b1;
    @(posedge clk);
    flush <= 1'b0;
  endtask

  // hit is checked in the request cycle and the result one cycle later
  task automatic run_access();
    int unsigned errors_before;
    errors_before = error_cnt;
    @(posedge clk);
    lsu_req        <= 1'b1;
    lsu_vaddr      <= t_vaddr;
    lsu_is_store   <= t_store;
    misaligned     <= t_mis;
    priv           <= t_priv;
    en_translation <= t_en;
    sum            <= t_sum;
    mxr            <= t_mxr;
    @(negedge clk);
    check_value("hit", 64'(lsu_dtlb_hit), 64'(t_hit));
    @(posedge clk);
    lsu_req    <= 1'b0;
    misaligned <= 1'b0;
    @(negedge clk);
    check_value("valid", 64'(lsu_valid), 64'(t_valid));
    check_value("exception valid", 64'(lsu_exception.valid), 64'(t_exc));
    if (t_valid && !t_exc) begin
      check_value("paddr", 64'(lsu_paddr), 64'(t_paddr));
    end
    if (t_exc) begin
      check_value("cause", 64'(lsu_exception.cause), 64'(t_cause));
      check_value("tval", 64'(lsu_exception.tval), 64'(t_vaddr));
    end
    test_cnt++;
    $display("test %0d access %h: %s", test_cnt, t_vaddr,
             (error_cnt == errors_before) ? "ok" : "mismatch");
  endtask

  // ----------------------------------------------------------------------
  // trace player
  // ----------------------------------------------------------------------
  initial begin
    int               fd;
    int               fields;
    int unsigned      records;
    logic             done;
    logic             run_failed;
    logic [63:0]      kind;
    logic [8*128-1:0] skip_line;
    logic [19:0]      r_vpn;
    logic             r_mega;
    logic [31:0]      r_pte;

    rst_n          = 1'b0;
    flush          = 1'b0;
    lsu_req        = 1'b0;
    lsu_vaddr      = '0;
    lsu_is_store   = 1'b0;
    misaligned     = 1'b0;
    priv           = mmu_pkg::PRIV_S;
    en_translation = 1'b0;
    sum            = 1'b0;
    mxr            = 1'b0;
    upd_valid      = 1'b0;
    upd_vpn        = '0;
    upd_mega       = 1'b0;
    upd_pte        = '0;
    test_cnt       = 0;
    check_cnt      = 0;
    error_cnt      = 0;
    run_failed     = 1'b0;
    done           = 1'b0;
    records        = 0;

    for (int i = 0; i < 10; i++) begin
      @(posedge clk);
    end
    rst_n <= 1'b1;

    fd = $fopen("mmu_trace.txt", "r");
    if (fd == 0) begin
      $display("could not open the trace file mmu_trace.txt");
      run_failed = 1'b1;
    end else begin
      while (!done && records < MAX_RECORDS) begin
        fields = $fscanf(fd, "%s", kind);
        if (fields != 1) begin
          done = 1'b1;
        end else if (kind == 64'("#")) begin
          fields = $fgets(skip_line, fd);
        end else if (kind == 64'("refill")) begin
          fields = $fscanf(fd, "%h %h %h", r_vpn, r_mega, r_pte);
          if (fields != 3) begin
            $display("malformed refill record %0d in the trace", records);
            run_failed = 1'b1;
            done       = 1'b1;
          end else begin
            refill_tlb(r_vpn, r_mega, r_pte);
          end
        end else if (kind == 64'("flush")) begin
          flush_tlb();
        end else if (kind == 64'("access")) begin
          fields = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h",
                           t_vaddr, t_store, t_mis, t_priv, t_en, t_sum, t_mxr,
                           t_hit, t_valid, t_paddr, t_exc, t_cause);
          if (fields != 12) begin
            $display("malformed access record %0d in the trace", records);
            run_failed = 1'b1;
            done       = 1'b1;
          end else begin
            run_access();
          end
        end else begin
          $display("unknown record kind in the trace at record %0d", records);
          run_failed = 1'b1;
          done       = 1'b1;
        end
        records++;
      end
      if (!done) begin
        $display("trace did not end within %0d records", MAX_RECORDS);
        run_failed = 1'b1;
      end
      $fclose(fd);
    end

    $display("tests %0d, checks %0d, errors %0d", test_cnt, check_cnt, error_cnt);
    if (error_cnt == 0 && !run_failed) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- xlate_result.sv
/*
 * Translation result stage
 * registers the lookup, forms the physical address and selects the
 * misaligned or page fault exception one cycle after the request
 */
`default_nettype none

module xlate_result (
  input  wire logic                      clk_i,
  input  wire logic                      rst_ni,
  input  wire logic                      req_i,
  input  wire logic                      xlate_on_i,
  input  wire logic                      is_store_i,
  input  wire logic                      mis_i,
  input  wire logic [1:0]                priv_i,
  input  wire logic                      sum_i,
  input  wire logic                      mxr_i,
  input  wire mmu_pkg::vaddr_u           vaddr_i,
  dtlb_if.monitor                        lu,
  output logic                           lsu_dtlb_hit_o,
  output logic                           lsu_valid_o,
  output logic [mmu_pkg::PLEN-1:0]       lsu_paddr_o,
  output mmu_pkg::exc_t                  lsu_exception_o
);

  logic                     req_q;
  logic                     xlate_on_q;
  logic                     mis_q;
  logic                     hit_q;
  logic                     is_store_q;
  logic [1:0]               priv_q;
  logic                     sum_q;
  logic                     mxr_q;
  logic                     mega_q;
  mmu_pkg::vaddr_u          vaddr_q;
  mmu_pkg::pte_t            pte_q;

  logic [mmu_pkg::PPNW-1:0] ppn;
  logic                     priv_err;
  logic                     perm_err;
  logic                     page_fault;

  // with translation off every access counts as a hit in cycle 0
  assign lsu_dtlb_hit_o = xlate_on_i ? lu.hit : 1'b1;

  // ----------------------------------------------------------------------
  // stage register
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_q      <= 1'b0;
      xlate_on_q <= 1'b0;
      mis_q      <= 1'b0;
      hit_q      <= 1'b0;
    end else begin
      req_q      <= req_i;
      xlate_on_q <= xlate_on_i;
      mis_q      <= mis_i;
      hit_q      <= lu.hit;
    end
  end

  always_ff @(posedge clk_i) begin
    is_store_q <= is_store_i;
    priv_q     <= priv_i;
    sum_q      <= sum_i;
    mxr_q      <= mxr_i;
    vaddr_q    <= vaddr_i;
    pte_q      <= lu.pte;
    mega_q     <= lu.mega;
  end

  // ----------------------------------------------------------------------
  // physical address
  // ----------------------------------------------------------------------
  assign ppn = {pte_q.ppn1, pte_q.ppn0};

  always_comb begin
    if (!xlate_on_q) begin
      lsu_paddr_o = {{(mmu_pkg::PLEN - mmu_pkg::VLEN){1'b0}}, vaddr_q};
    end else if (mega_q) begin
      // vpn0 passes through in place of the megapage ppn0
      lsu_paddr_o = {ppn[mmu_pkg::PPNW-1:10], vaddr_q.mega.offset};
    end else begin
      lsu_paddr_o = {ppn, vaddr_q.page.offset};
    end
  end

  // ----------------------------------------------------------------------
  // fault checks
  // ----------------------------------------------------------------------
  // user pages need SUM from supervisor and supervisor pages are off limits to user
  assign priv_err = ((priv_q == mmu_pkg::PRIV_U) && !pte_q.u)
                 || ((priv_q == mmu_pkg::PRIV_S) && pte_q.u && !sum_q);

  // stores need W and D set, loads need R or X with MXR on
  assign perm_err = is_store_q ? (!pte_q.w || !pte_q.d)
                               : !(pte_q.r || (mxr_q && pte_q.x));

  assign page_fault = req_q && xlate_on_q && hit_q && (!pte_q.a || priv_err || perm_err);

  // a translated miss never completes and the requester refills and retries
  assign lsu_valid_o = req_q && (!xlate_on_q || hit_q || mis_q);

  always_comb begin
    lsu_exception_o = '0;
    if (mis_q) begin
      lsu_exception_o.valid = 1'b1;
      lsu_exception_o.cause = is_store_q ? mmu_pkg::CAUSE_ST_MISALIGNED
                                         : mmu_pkg::CAUSE_LD_MISALIGNED;
      lsu_exception_o.tval  = vaddr_q;
    end else if (page_fault) begin
      lsu_exception_o.valid = 1'b1;
      lsu_exception_o.cause = is_store_q ? mmu_pkg::CAUSE_ST_PAGE_FAULT
                                         : mmu_pkg::CAUSE_LD_PAGE_FAULT;
      lsu_exception_o.tval  = vaddr_q;
    end
  end

endmodule

`default_nettype wire
